// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mem_tile
SEED      ?= 67
LOG       ?= sim.log
BUILD_DIR ?= obj_dir
PASS_MSG  := No errors
BIN       := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build:
	$(VERILATOR) --binary --timing -Wno-fatal -f filelist.f --top-module $(TOP) \
		-GSEED=$(SEED) --Mdir $(BUILD_DIR)

run: build
	./$(BIN) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== filelist.f ====
+incdir+.
src/tile_pkg.sv
src/tile_cfg_regs.sv
src/core_addr_router.sv
src/tcdm_bank.sv
src/bank_xbar.sv
src/mem_tile.sv
tests/tb_mem_tile.sv

// ==== src/bank_xbar.sv ====
// Local crossbar with per-bank round-robin arbitration over the cores and the remote port
module bank_xbar
  import tile_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  bank_req_t [NumIni-1:0]   ini_req_i,
  input  logic      [NumIni-1:0]   ini_req_valid_i,
  output logic      [NumIni-1:0]   ini_req_ready_o,
  output bank_rsp_t [NumIni-1:0]   ini_rsp_o,
  output logic      [NumIni-1:0]   ini_rsp_valid_o,
  input  logic      [NumIni-1:0]   ini_rsp_ready_i,
  input  bank_sel_t [NumIni-1:0]   bank_sel_i
);

  bank_req_t [NumBanks-1:0] bank_req;
  logic      [NumBanks-1:0] bank_req_valid;
  logic      [NumBanks-1:0] bank_req_ready;
  bank_rsp_t [NumBanks-1:0] bank_rsp;
  logic      [NumBanks-1:0] bank_rsp_valid;
  logic      [NumBanks-1:0] bank_rsp_ready;
  ini_idx_t  [NumBanks-1:0] gnt_idx;
  ini_idx_t  [NumBanks-1:0] rr_q;
  bank_sel_t [NumIni-1:0]   rsp_src;

  for (genvar b = 0; b < NumBanks; b++) begin : gen_bank
    // Search starts at the round-robin pointer
    always_comb begin
      int unsigned idx;
      bank_req_valid[b] = 1'b0;
      gnt_idx[b]        = '0;
      for (int unsigned k = 0; k < NumIni; k++) begin
        idx = (int'(rr_q[b]) + k) % NumIni;
        if (!bank_req_valid[b] && ini_req_valid_i[idx] && bank_sel_i[idx] == bank_sel_t'(b)) begin
          bank_req_valid[b] = 1'b1;
          gnt_idx[b]        = ini_idx_t'(idx);
        end
      end
      bank_req[b]     = ini_req_i[gnt_idx[b]];
      bank_req[b].ini = gnt_idx[b];
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        rr_q[b] <= '0;
      end else if (bank_req_valid[b] && bank_req_ready[b]) begin
        rr_q[b] <= (gnt_idx[b] == ini_idx_t'(NumIni - 1)) ? '0 : gnt_idx[b] + 1'b1;
      end
    end

    tcdm_bank i_bank (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .req_i       (bank_req[b]),
      .req_valid_i (bank_req_valid[b]),
      .req_ready_o (bank_req_ready[b]),
      .rsp_o       (bank_rsp[b]),
      .rsp_valid_o (bank_rsp_valid[b]),
      .rsp_ready_i (bank_rsp_ready[b])
    );
  end

  for (genvar i = 0; i < NumIni; i++) begin : gen_ini_ready
    assign ini_req_ready_o[i] = bank_req_valid[bank_sel_i[i]] &
                                (gnt_idx[bank_sel_i[i]] == ini_idx_t'(i)) &
                                bank_req_ready[bank_sel_i[i]];
  end

  // Lowest bank wins when two banks answer the same initiator
  always_comb begin
    ini_rsp_o       = '0;
    ini_rsp_valid_o = '0;
    rsp_src         = '0;
    bank_rsp_ready  = '0;
    for (int b = NumBanks - 1; b >= 0; b--) begin
      if (bank_rsp_valid[b]) begin
        ini_rsp_o[bank_rsp[b].ini]       = bank_rsp[b];
        ini_rsp_valid_o[bank_rsp[b].ini] = 1'b1;
        rsp_src[bank_rsp[b].ini]         = bank_sel_t'(b);
      end
    end
    for (int b = 0; b < NumBanks; b++) begin
      bank_rsp_ready[b] = ini_rsp_ready_i[bank_rsp[b].ini] &
                          (rsp_src[bank_rsp[b].ini] == bank_sel_t'(b));
    end
  end

endmodule

// ==== src/core_addr_router.sv ====
// Per-core address decode into local, remote or error paths, plus merge of the three responses
module core_addr_router
  import tile_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_ni,
  input  tile_cfg_t       cfg_i,
  input  core_req_t       core_req_i,
  input  logic            core_req_valid_i,
  output logic            core_req_ready_o,
  output core_rsp_t       core_rsp_o,
  output logic            core_rsp_valid_o,
  input  logic            core_rsp_ready_i,
  output local_req_t      local_req_o,
  output logic            local_req_valid_o,
  input  logic            local_req_ready_i,
  input  bank_rsp_t       local_rsp_i,
  input  logic            local_rsp_valid_i,
  output logic            local_rsp_ready_o,
  output remote_out_req_t remote_req_o,
  output logic            remote_req_valid_o,
  input  logic            remote_req_ready_i,
  input  core_rsp_t       remote_rsp_i,
  input  logic            remote_rsp_valid_i,
  output logic            remote_rsp_ready_o
);

  addr_t     addr;
  logic      in_region;
  tile_id_t  tile_field;
  bank_sel_t bank_field;
  row_t      row_field;
  dest_e     dest;
  logic      req_open;
  logic      err_valid_q;
  id_t       err_id_q;

  assign addr       = core_req_i.addr;
  assign in_region  = (addr & RegionMask) == cfg_i.tcdm_base;
  assign tile_field = addr[TileLsb +: TileSelW];
  assign bank_field = addr[BankLsb +: BankSelW];
  assign row_field  = addr[RowLsb +: RowW];
  assign dest = !in_region ? DEST_INVALID :
                (tile_field == cfg_i.tile_id) ? DEST_LOCAL : DEST_REMOTE;

  // A pending error response blocks new requests
  assign req_open = core_req_valid_i & ~err_valid_q;

  assign local_req_o = '{row: row_field, write: core_req_i.write, data: core_req_i.data,
                         be: core_req_i.be, id: core_req_i.id};
  assign local_req_valid_o = req_open & (dest == DEST_LOCAL);

  // Tile and bank swap places for routing between tiles
  assign remote_req_o = '{addr: {addr[AddrWidth-1:RegionW], row_field, bank_field, tile_field,
                                 addr[ByteOffW-1:0]},
                          write: core_req_i.write, data: core_req_i.data,
                          be: core_req_i.be, id: core_req_i.id};
  assign remote_req_valid_o = req_open & (dest == DEST_REMOTE);

  always_comb begin
    case (dest)
      DEST_LOCAL:  core_req_ready_o = ~err_valid_q & local_req_ready_i;
      DEST_REMOTE: core_req_ready_o = ~err_valid_q & remote_req_ready_i;
      default:     core_req_ready_o = ~err_valid_q;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_valid_q <= 1'b0;
    end else if (req_open && dest == DEST_INVALID) begin
      err_valid_q <= 1'b1;
    end else if (err_valid_q && !local_rsp_valid_i && core_rsp_ready_i) begin
      err_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_open && dest == DEST_INVALID) begin
      err_id_q <= core_req_i.id;
    end
  end

  // Fixed priority: local, error, remote
  always_comb begin
    if (local_rsp_valid_i) begin
      core_rsp_o = '{data: local_rsp_i.data, id: local_rsp_i.id.id, err: 1'b0};
    end else if (err_valid_q) begin
      core_rsp_o = '{data: '0, id: err_id_q, err: 1'b1};
    end else begin
      core_rsp_o = remote_rsp_i;
    end
  end

  assign core_rsp_valid_o   = local_rsp_valid_i | err_valid_q | remote_rsp_valid_i;
  assign local_rsp_ready_o  = core_rsp_ready_i;
  assign remote_rsp_ready_o = core_rsp_ready_i & ~local_rsp_valid_i & ~err_valid_q;

endmodule

// ==== src/mem_tile.sv ====
// Top of the memory tile joining configuration, per-core routers and the banked crossbar
module mem_tile
  import tile_pkg::*;
(
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  apb_req_t                          apb_req_i,
  output apb_rsp_t                          apb_rsp_o,
  input  core_req_t       [NumCores-1:0]    core_req_i,
  input  logic            [NumCores-1:0]    core_req_valid_i,
  output logic            [NumCores-1:0]    core_req_ready_o,
  output core_rsp_t       [NumCores-1:0]    core_rsp_o,
  output logic            [NumCores-1:0]    core_rsp_valid_o,
  input  logic            [NumCores-1:0]    core_rsp_ready_i,
  output remote_out_req_t [NumCores-1:0]    remote_req_o,
  output logic            [NumCores-1:0]    remote_req_valid_o,
  input  logic            [NumCores-1:0]    remote_req_ready_i,
  input  core_rsp_t       [NumCores-1:0]    remote_rsp_i,
  input  logic            [NumCores-1:0]    remote_rsp_valid_i,
  output logic            [NumCores-1:0]    remote_rsp_ready_o,
  input  remote_in_req_t                    remote_in_req_i,
  input  logic                              remote_in_req_valid_i,
  output logic                              remote_in_req_ready_o,
  output remote_in_rsp_t                    remote_in_rsp_o,
  output logic                              remote_in_rsp_valid_o,
  input  logic                              remote_in_rsp_ready_i
);

  tile_cfg_t                cfg;
  local_req_t [NumCores-1:0] local_req;
  bank_req_t  [NumIni-1:0]   ini_req;
  logic       [NumIni-1:0]   ini_req_valid;
  logic       [NumIni-1:0]   ini_req_ready;
  bank_rsp_t  [NumIni-1:0]   ini_rsp;
  logic       [NumIni-1:0]   ini_rsp_valid;
  logic       [NumIni-1:0]   ini_rsp_ready;
  bank_sel_t  [NumIni-1:0]   bank_sel;

  tile_cfg_regs i_cfg (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .apb_req_i (apb_req_i),
    .apb_rsp_o (apb_rsp_o),
    .cfg_o     (cfg)
  );

  for (genvar c = 0; c < NumCores; c++) begin : gen_core
    // Initiator index is filled in by the crossbar on grant
    assign ini_req[c] = '{row: local_req[c].row, write: local_req[c].write,
                          data: local_req[c].data, be: local_req[c].be,
                          id: '{tile: cfg.tile_id, id: local_req[c].id}, ini: '0};
    assign bank_sel[c] = core_req_i[c].addr[BankLsb +: BankSelW];

    core_addr_router i_router (
      .clk_i (clk_i), .rst_ni (rst_ni), .cfg_i (cfg),
      .core_req_i (core_req_i[c]), .core_req_valid_i (core_req_valid_i[c]),
      .core_req_ready_o (core_req_ready_o[c]),
      .core_rsp_o (core_rsp_o[c]), .core_rsp_valid_o (core_rsp_valid_o[c]),
      .core_rsp_ready_i (core_rsp_ready_i[c]),
      .local_req_o (local_req[c]), .local_req_valid_o (ini_req_valid[c]),
      .local_req_ready_i (ini_req_ready[c]),
      .local_rsp_i (ini_rsp[c]), .local_rsp_valid_i (ini_rsp_valid[c]),
      .local_rsp_ready_o (ini_rsp_ready[c]),
      .remote_req_o (remote_req_o[c]), .remote_req_valid_o (remote_req_valid_o[c]),
      .remote_req_ready_i (remote_req_ready_i[c]),
      .remote_rsp_i (remote_rsp_i[c]), .remote_rsp_valid_i (remote_rsp_valid_i[c]),
      .remote_rsp_ready_o (remote_rsp_ready_o[c])
    );
  end

  // Remote slave port is the last initiator
  assign ini_req[NumCores] = '{row: remote_in_req_i.row, write: remote_in_req_i.write,
                               data: remote_in_req_i.data, be: remote_in_req_i.be,
                               id: '{tile: remote_in_req_i.ini_tile, id: remote_in_req_i.id},
                               ini: '0};
  assign bank_sel[NumCores]      = remote_in_req_i.bank;
  assign ini_req_valid[NumCores] = remote_in_req_valid_i;
  assign remote_in_req_ready_o   = ini_req_ready[NumCores];
  assign remote_in_rsp_o = '{ini_tile: ini_rsp[NumCores].id.tile, data: ini_rsp[NumCores].data,
                             id: ini_rsp[NumCores].id.id};
  assign remote_in_rsp_valid_o   = ini_rsp_valid[NumCores];
  assign ini_rsp_ready[NumCores] = remote_in_rsp_ready_i;

  bank_xbar i_xbar (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .ini_req_i       (ini_req),
    .ini_req_valid_i (ini_req_valid),
    .ini_req_ready_o (ini_req_ready),
    .ini_rsp_o       (ini_rsp),
    .ini_rsp_valid_o (ini_rsp_valid),
    .ini_rsp_ready_i (ini_rsp_ready),
    .bank_sel_i      (bank_sel)
  );

endmodule

// ==== src/tcdm_bank.sv ====
// One TCDM SRAM bank with byte-enabled writes and a held read response
module tcdm_bank
  import tile_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  bank_req_t req_i,
  input  logic      req_valid_i,
  output logic      req_ready_o,
  output bank_rsp_t rsp_o,
  output logic      rsp_valid_o,
  input  logic      rsp_ready_i
);

  data_t mem_q [BankWords];
  data_t bit_en;
  logic  fire;
  logic  rsp_valid_q;

  for (genvar i = 0; i < BeWidth; i++) begin : gen_bit_en
    assign bit_en[8*i +: 8] = {8{req_i.be[i]}};
  end

  // Idle, or the held response leaves this cycle
  assign req_ready_o = ~rsp_valid_q | rsp_ready_i;
  assign fire        = req_valid_i & req_ready_o;

  always_ff @(posedge clk_i) begin
    if (fire && req_i.write) begin
      mem_q[req_i.row] <= (mem_q[req_i.row] & ~bit_en) | (req_i.data & bit_en);
    end
  end

  always_ff @(posedge clk_i) begin
    if (fire && !req_i.write) begin
      rsp_o.data <= mem_q[req_i.row];
      rsp_o.id   <= req_i.id;
      rsp_o.ini  <= req_i.ini;
    end
  end

  // Writes never answer
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_valid_q <= 1'b0;
    end else if (req_ready_o) begin
      rsp_valid_q <= fire & ~req_i.write;
    end
  end

  assign rsp_valid_o = rsp_valid_q;

endmodule

// ==== src/tile_cfg_regs.sv ====
// APB register block holding the tile ID and TCDM base that steer every address router
module tile_cfg_regs
  import tile_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  apb_req_t  apb_req_i,
  output apb_rsp_t  apb_rsp_o,
  output tile_cfg_t cfg_o
);

  logic     access;
  tile_id_t tile_id_q;
  addr_t    tcdm_base_q;

  // Access phase of a selected transfer, never stretched
  assign access = apb_req_i.psel & apb_req_i.penable;

  always_comb begin
    apb_rsp_o.prdata  = '0;
    apb_rsp_o.pready  = access;
    apb_rsp_o.pslverr = 1'b0;
    case (apb_req_i.paddr)
      CFG_TILE_ID: begin
        apb_rsp_o.prdata = data_t'(tile_id_q);
      end
      CFG_TCDM_BASE: begin
        apb_rsp_o.prdata = tcdm_base_q;
      end
      default: begin
        apb_rsp_o.pslverr = access;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tile_id_q   <= ResetTileId;
      tcdm_base_q <= ResetBase;
    end else if (access && apb_req_i.pwrite) begin
      case (apb_req_i.paddr)
        CFG_TILE_ID: begin
          tile_id_q <= apb_req_i.pwdata[TileSelW-1:0];
        end
        CFG_TCDM_BASE: begin
          // Base stays aligned to the region size
          tcdm_base_q <= apb_req_i.pwdata & RegionMask;
        end
        default: begin
          tile_id_q <= tile_id_q;
        end
      endcase
    end
  end

  assign cfg_o.tile_id   = tile_id_q;
  assign cfg_o.tcdm_base = tcdm_base_q;

endmodule

// ==== src/tile_pkg.sv ====
// Shared types, derived widths and encodings of the memory tile, imported by every module
`include "tile_config.svh"

package tile_pkg;

  localparam int unsigned NumCores  = `TILE_NUM_CORES;
  localparam int unsigned NumBanks  = `TILE_NUM_BANKS;
  localparam int unsigned NumTiles  = `TILE_NUM_TILES;
  localparam int unsigned BankWords = `TILE_BANK_WORDS;
  localparam int unsigned DataWidth = `TILE_DATA_WIDTH;
  localparam int unsigned AddrWidth = `TILE_ADDR_WIDTH;
  localparam int unsigned IdWidth   = `TILE_ID_WIDTH;
  // Cores first, the remote slave port takes the last initiator slot
  localparam int unsigned NumIni    = NumCores + 1;
  localparam int unsigned BeWidth   = DataWidth / 8;

  // Address layout inside the region: byte offset, bank, tile, row
  localparam int unsigned ByteOffW = $clog2(BeWidth);
  localparam int unsigned BankSelW = $clog2(NumBanks);
  localparam int unsigned TileSelW = $clog2(NumTiles);
  localparam int unsigned RowW     = $clog2(BankWords);
  localparam int unsigned IniIdxW  = $clog2(NumIni);
  localparam int unsigned BankLsb  = ByteOffW;
  localparam int unsigned TileLsb  = BankLsb + BankSelW;
  localparam int unsigned RowLsb   = TileLsb + TileSelW;
  localparam int unsigned RegionW  = RowLsb + RowW;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [BeWidth-1:0]   be_t;
  typedef logic [IdWidth-1:0]   id_t;
  typedef logic [TileSelW-1:0]  tile_id_t;
  typedef logic [BankSelW-1:0]  bank_sel_t;
  typedef logic [RowW-1:0]      row_t;
  typedef logic [IniIdxW-1:0]   ini_idx_t;

  // 16 KiB aligned region
  localparam addr_t    RegionMask  = {AddrWidth{1'b1}} << RegionW;
  localparam addr_t    ResetBase   = `TILE_RESET_BASE;
  localparam tile_id_t ResetTileId = `TILE_RESET_ID;

  typedef struct packed {addr_t addr; logic write; data_t data; be_t be; id_t id;} core_req_t;
  typedef struct packed {data_t data; id_t id; logic err;} core_rsp_t;
  typedef struct packed {addr_t addr; logic write; data_t data; be_t be; id_t id;} remote_out_req_t;

  typedef struct packed {
    tile_id_t ini_tile; row_t row; bank_sel_t bank; logic write; data_t data; be_t be; id_t id;
  } remote_in_req_t;
  typedef struct packed {tile_id_t ini_tile; data_t data; id_t id;} remote_in_rsp_t;

  // Bank-side id keeps the requesting tile next to the transaction id
  typedef struct packed {tile_id_t tile; id_t id;} tag_t;
  typedef struct packed {row_t row; logic write; data_t data; be_t be; id_t id;} local_req_t;
  typedef struct packed {
    row_t row; logic write; data_t data; be_t be; tag_t id; ini_idx_t ini;
  } bank_req_t;
  typedef struct packed {data_t data; tag_t id; ini_idx_t ini;} bank_rsp_t;

  typedef struct packed {tile_id_t tile_id; addr_t tcdm_base;} tile_cfg_t;
  typedef struct packed {logic psel; logic penable; logic pwrite; logic [7:0] paddr; data_t pwdata;} apb_req_t;
  typedef struct packed {data_t prdata; logic pready; logic pslverr;} apb_rsp_t;

  typedef enum logic [7:0] {CFG_TILE_ID = 8'h0, CFG_TCDM_BASE = 8'h4} cfg_reg_e;
  typedef enum logic [1:0] {DEST_LOCAL, DEST_REMOTE, DEST_INVALID} dest_e;

endpackage

// ==== tests/tb_mem_tile.sv ====
// Directed testbench that drives the memory tile through APB setup, local, remote and contended accesses
`include "tile_config.svh"

module tb_mem_tile
  import tile_pkg::*;
#(
  parameter int unsigned SEED = 67
);

  localparam int ClkPeriod     = 8;
  localparam int NumTests      = 6;
  localparam int CyclesPerTest = 200;

  logic                              clk_i;
  logic                              rst_ni;
  apb_req_t                          apb_req;
  apb_rsp_t                          apb_rsp;
  core_req_t       [NumCores-1:0]    core_req;
  logic            [NumCores-1:0]    core_req_valid;
  logic            [NumCores-1:0]    core_req_ready;
  core_rsp_t       [NumCores-1:0]    core_rsp;
  logic            [NumCores-1:0]    core_rsp_valid;
  logic            [NumCores-1:0]    core_rsp_ready;
  remote_out_req_t [NumCores-1:0]    remote_req;
  logic            [NumCores-1:0]    remote_req_valid;
  logic            [NumCores-1:0]    remote_req_ready;
  core_rsp_t       [NumCores-1:0]    remote_rsp;
  logic            [NumCores-1:0]    remote_rsp_valid;
  logic            [NumCores-1:0]    remote_rsp_ready;
  remote_in_req_t                    remote_in_req;
  logic                              remote_in_req_valid;
  logic                              remote_in_req_ready;
  remote_in_rsp_t                    remote_in_rsp;
  logic                              remote_in_rsp_valid;
  logic                              remote_in_rsp_ready;

  int              value_errors     = 0;
  int              other_errors     = 0;
  int              remote_req_seen  = 0;
  int              remote_rsp_taken = 0;
  remote_out_req_t last_remote_req;
  addr_t           tcdm_base        = `TILE_RESET_BASE;

  mem_tile dut0 (
    .clk_i (clk_i), .rst_ni (rst_ni), .apb_req_i (apb_req), .apb_rsp_o (apb_rsp),
    .core_req_i (core_req), .core_req_valid_i (core_req_valid),
    .core_req_ready_o (core_req_ready), .core_rsp_o (core_rsp),
    .core_rsp_valid_o (core_rsp_valid), .core_rsp_ready_i (core_rsp_ready),
    .remote_req_o (remote_req), .remote_req_valid_o (remote_req_valid),
    .remote_req_ready_i (remote_req_ready), .remote_rsp_i (remote_rsp),
    .remote_rsp_valid_i (remote_rsp_valid), .remote_rsp_ready_o (remote_rsp_ready),
    .remote_in_req_i (remote_in_req), .remote_in_req_valid_i (remote_in_req_valid),
    .remote_in_req_ready_o (remote_in_req_ready), .remote_in_rsp_o (remote_in_rsp),
    .remote_in_rsp_valid_o (remote_in_rsp_valid), .remote_in_rsp_ready_i (remote_in_rsp_ready)
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  // Handshakes on core 0's remote master port
  always @(negedge clk_i) begin
    if (rst_ni && remote_req_valid[0] && remote_req_ready[0]) begin
      remote_req_seen++;
      last_remote_req = remote_req[0];
    end
    if (rst_ni && remote_rsp_valid[0] && remote_rsp_ready[0]) begin
      remote_rsp_taken++;
    end
  end

  task automatic report_mismatch(input string name, input logic [127:0] got,
                                 input logic [127:0] exp);
    $display("** Error: %s = 0x%0h, expected 0x%0h at time %0t", name, got, exp, $time);
    value_errors++;
  endtask

  task automatic report_failure(input string what);
    $display("Failure at time %0t: %s", $time, what);
    other_errors++;
  endtask

  task automatic print_counts();
    $display("Run ended with %0d value errors and %0d other failures", value_errors,
             other_errors);
  endtask

  // Tile-local layout has the bank above the byte offset, then tile and row
  function automatic addr_t local_addr(int tile, int bank, int row);
    return tcdm_base | (addr_t'(row) << 6) | (addr_t'(tile) << 4) | (addr_t'(bank) << 2);
  endfunction

  // Between tiles the tile field sits below the bank
  function automatic addr_t scrambled_addr(int tile, int bank, int row);
    return tcdm_base | (addr_t'(row) << 6) | (addr_t'(bank) << 4) | (addr_t'(tile) << 2);
  endfunction

  task automatic apb_access(input logic write, input logic [7:0] offset, input data_t wdata,
                            output data_t rdata, output logic slverr);
    apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: offset, pwdata: wdata};
    @(posedge clk_i);
    #1;
    apb_req.penable = 1'b1;
    @(negedge clk_i);
    if (!apb_rsp.pready) report_failure("APB access phase without pready");
    rdata  = apb_rsp.prdata;
    slverr = apb_rsp.pslverr;
    @(posedge clk_i);
    #1;
    apb_req = '0;
  endtask

  task automatic send_core_req(input int c, input core_req_t req);
    core_req[c]       = req;
    core_req_valid[c] = 1'b1;
    do @(negedge clk_i); while (!core_req_ready[c]);
    @(posedge clk_i);
    #1;
    core_req_valid[c] = 1'b0;
  endtask

  task automatic send_remote_req(input remote_in_req_t req);
    remote_in_req       = req;
    remote_in_req_valid = 1'b1;
    do @(negedge clk_i); while (!remote_in_req_ready);
    @(posedge clk_i);
    #1;
    remote_in_req_valid = 1'b0;
  endtask

  // Throttle toggles the response ready at random each cycle
  task automatic take_core_rsp(input int c, input bit throttle, output core_rsp_t rsp);
    bit done;
    done = 1'b0;
    while (!done) begin
      if (throttle) core_rsp_ready[c] = 1'($urandom % 2);
      @(negedge clk_i);
      if (core_rsp_valid[c] && core_rsp_ready[c]) begin
        rsp  = core_rsp[c];
        done = 1'b1;
      end
      @(posedge clk_i);
      #1;
    end
    core_rsp_ready[c] = 1'b1;
  endtask

  task automatic take_remote_rsp(input bit throttle, output remote_in_rsp_t rsp);
    bit done;
    done = 1'b0;
    while (!done) begin
      if (throttle) remote_in_rsp_ready = 1'($urandom % 2);
      @(negedge clk_i);
      if (remote_in_rsp_valid && remote_in_rsp_ready) begin
        rsp  = remote_in_rsp;
        done = 1'b1;
      end
      @(posedge clk_i);
      #1;
    end
    remote_in_rsp_ready = 1'b1;
  endtask

  task automatic check_cfg_registers();
    data_t rdata;
    logic  slverr;
    if (core_rsp_valid !== '0 || remote_req_valid !== '0 || remote_in_rsp_valid !== 1'b0)
      report_failure("a valid output is high after reset");
    apb_access(1'b0, 8'h0, '0, rdata, slverr);
    if (rdata !== data_t'(`TILE_RESET_ID)) report_mismatch("prdata", rdata, `TILE_RESET_ID);
    if (slverr !== 1'b0) report_mismatch("pslverr", slverr, 0);
    apb_access(1'b0, 8'h4, '0, rdata, slverr);
    if (rdata !== `TILE_RESET_BASE) report_mismatch("prdata", rdata, `TILE_RESET_BASE);
    apb_access(1'b1, 8'h4, 32'h0002_3abc, rdata, slverr);
    tcdm_base = 32'h0002_3abc & ~32'h0000_3fff;
    apb_access(1'b0, 8'h4, '0, rdata, slverr);
    if (rdata !== tcdm_base) report_mismatch("prdata", rdata, tcdm_base);
    apb_access(1'b1, 8'h0, 32'h7, rdata, slverr);
    apb_access(1'b0, 8'h0, '0, rdata, slverr);
    if (rdata !== 32'h3) report_mismatch("prdata", rdata, 32'h3);
    apb_access(1'b0, 8'h8, '0, rdata, slverr);
    if (slverr !== 1'b1) report_mismatch("pslverr", slverr, 1);
  endtask

  task automatic merge_byte_writes();
    data_t     rdata;
    logic      slverr;
    data_t     d_lo;
    data_t     d_hi;
    data_t     expected;
    id_t       id;
    addr_t     addr;
    core_rsp_t rsp;
    apb_access(1'b1, 8'h0, 32'h1, rdata, slverr);
    d_lo     = $urandom;
    d_hi     = $urandom;
    id       = id_t'($urandom);
    addr     = local_addr(1, 2, 5);
    expected = {d_hi[31:16], d_lo[15:0]};
    send_core_req(0, '{addr: addr, write: 1'b1, data: d_lo, be: 4'b0011, id: id});
    send_core_req(0, '{addr: addr, write: 1'b1, data: d_hi, be: 4'b1100, id: id});
    id = id_t'($urandom);
    send_core_req(0, '{addr: addr, write: 1'b0, data: '0, be: 4'hf, id: id});
    take_core_rsp(0, 1'b0, rsp);
    if (rsp.data !== expected) report_mismatch("core_rsp_o[0].data", rsp.data, expected);
    if (rsp.id !== id) report_mismatch("core_rsp_o[0].id", rsp.id, id);
    if (rsp.err !== 1'b0) report_mismatch("core_rsp_o[0].err", rsp.err, 0);
  endtask

  task automatic share_bank_with_remote();
    data_t          wdata;
    id_t            id;
    remote_in_rsp_t rsp;
    wdata = $urandom;
    id    = id_t'($urandom);
    send_core_req(1, '{addr: local_addr(1, 1, 9), write: 1'b1, data: wdata, be: 4'hf, id: id});
    id = id_t'($urandom);
    send_remote_req('{ini_tile: 2'd3, row: 8'd9, bank: 2'd1, write: 1'b0, data: '0,
                      be: 4'hf, id: id});
    take_remote_rsp(1'b0, rsp);
    if (rsp.data !== wdata) report_mismatch("remote_in_rsp_o.data", rsp.data, wdata);
    if (rsp.ini_tile !== 2'd3) report_mismatch("remote_in_rsp_o.ini_tile", rsp.ini_tile, 3);
    if (rsp.id !== id) report_mismatch("remote_in_rsp_o.id", rsp.id, id);
  endtask

  task automatic route_remote_access();
    core_req_t       req;
    remote_out_req_t expected;
    core_rsp_t       rsp;
    data_t           rdata;
    int              seen_before;
    int              taken_before;
    req      = '{addr: local_addr(2, 3, 17) | 32'h2, write: 1'b0, data: $urandom,
                 be: 4'b0101, id: id_t'($urandom)};
    expected = '{addr: scrambled_addr(2, 3, 17) | 32'h2, write: req.write, data: req.data,
                 be: req.be, id: req.id};
    seen_before = remote_req_seen;
    send_core_req(0, req);
    if (remote_req_seen != seen_before + 1) report_failure("remote request was not issued");
    if (last_remote_req.addr !== expected.addr)
      report_mismatch("remote_req_o[0].addr", last_remote_req.addr, expected.addr);
    if (last_remote_req !== expected)
      report_mismatch("remote_req_o[0]", last_remote_req, expected);
    rdata               = $urandom;
    taken_before        = remote_rsp_taken;
    remote_rsp[0]       = '{data: rdata, id: req.id, err: 1'b0};
    remote_rsp_valid[0] = 1'b1;
    take_core_rsp(0, 1'b0, rsp);
    remote_rsp_valid[0] = 1'b0;
    if (remote_rsp_taken != taken_before + 1)
      report_failure("remote response was not taken exactly once through remote_rsp_ready_o");
    if (rsp.data !== rdata) report_mismatch("core_rsp_o[0].data", rsp.data, rdata);
    if (rsp.id !== req.id) report_mismatch("core_rsp_o[0].id", rsp.id, req.id);
  endtask

  task automatic reject_out_of_region();
    core_req_t req;
    core_rsp_t rsp;
    int        seen_before;
    req = '{addr: (tcdm_base ^ 32'h0001_0000) | 32'h124, write: 1'b1, data: $urandom,
            be: 4'hf, id: id_t'($urandom)};
    seen_before = remote_req_seen;
    send_core_req(0, req);
    take_core_rsp(0, 1'b0, rsp);
    if (remote_req_seen != seen_before) report_failure("out-of-region access went remote");
    if (rsp.err !== 1'b1) report_mismatch("core_rsp_o[0].err", rsp.err, 1);
    if (rsp.data !== '0) report_mismatch("core_rsp_o[0].data", rsp.data, 0);
    if (rsp.id !== req.id) report_mismatch("core_rsp_o[0].id", rsp.id, req.id);
  endtask

  task automatic contend_one_bank();
    data_t          rows [3];
    id_t            ids [3];
    core_rsp_t      rsp0;
    core_rsp_t      rsp1;
    remote_in_rsp_t rspr;
    for (int r = 0; r < 3; r++) begin
      rows[r] = $urandom;
      ids[r]  = id_t'($urandom);
      send_core_req(0, '{addr: local_addr(1, 3, r + 1), write: 1'b1, data: rows[r],
                         be: 4'hf, id: ids[r]});
    end
    // All three initiators hit bank 3 in the same cycle
    fork
      send_core_req(0, '{addr: local_addr(1, 3, 1), write: 1'b0, data: '0, be: 4'hf,
                         id: ids[0]});
      send_core_req(1, '{addr: local_addr(1, 3, 2), write: 1'b0, data: '0, be: 4'hf,
                         id: ids[1]});
      send_remote_req('{ini_tile: 2'd0, row: 8'd3, bank: 2'd3, write: 1'b0, data: '0,
                        be: 4'hf, id: ids[2]});
      take_core_rsp(0, 1'b1, rsp0);
      take_core_rsp(1, 1'b1, rsp1);
      take_remote_rsp(1'b1, rspr);
    join
    if (rsp0.data !== rows[0]) report_mismatch("core_rsp_o[0].data", rsp0.data, rows[0]);
    if (rsp0.id !== ids[0]) report_mismatch("core_rsp_o[0].id", rsp0.id, ids[0]);
    if (rsp1.data !== rows[1]) report_mismatch("core_rsp_o[1].data", rsp1.data, rows[1]);
    if (rsp1.id !== ids[1]) report_mismatch("core_rsp_o[1].id", rsp1.id, ids[1]);
    if (rspr.data !== rows[2]) report_mismatch("remote_in_rsp_o.data", rspr.data, rows[2]);
    if (rspr.id !== ids[2]) report_mismatch("remote_in_rsp_o.id", rspr.id, ids[2]);
  endtask

  initial begin
    void'($urandom(SEED));
    clk_i               = 1'b0;
    rst_ni              = 1'b0;
    apb_req             = '0;
    core_req            = '0;
    core_req_valid      = '0;
    core_rsp_ready      = '1;
    remote_req_ready    = '1;
    remote_rsp          = '0;
    remote_rsp_valid    = '0;
    remote_in_req       = '0;
    remote_in_req_valid = 1'b0;
    remote_in_rsp_ready = 1'b1;
    repeat (2) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    check_cfg_registers();
    merge_byte_writes();
    share_bank_with_remote();
    route_remote_access();
    reject_out_of_region();
    contend_one_bank();
    print_counts();
    if (value_errors + other_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin
    #(ClkPeriod * CyclesPerTest * NumTests);
    report_failure("watchdog expired before the tests finished");
    print_counts();
    $display("Errors found");
    $finish;
  end

endmodule

// ==== tile_config.svh ====
// Build-time sizes, widths and reset values of the memory tile, included by the package and tests
`ifndef TILE_CONFIG_SVH
`define TILE_CONFIG_SVH

// Tile geometry
`define TILE_NUM_CORES 2
`define TILE_NUM_BANKS 4
`define TILE_NUM_TILES 4
`define TILE_BANK_WORDS 256

// Bus widths
`define TILE_DATA_WIDTH 32
`define TILE_ADDR_WIDTH 32
`define TILE_ID_WIDTH 4

// Configuration after reset
`define TILE_RESET_BASE 32'h0001_0000
`define TILE_RESET_ID 0

`endif
